// ==== design/frame_rx.sv ====
//********************
// parses &&payload&& from received bytes
// a lone '&' ends the payload and the next byte must be '&'
// bytes outside a frame are dropped silently
// rx_string above rx_length reads as zero
//********************
`timescale 1ns/100ps
`include "uart_frame_macros.svh"

module frame_rx (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  uart_frame_pkg::byte_beat_t    rx_beat,
	output uart_frame_pkg::frame_string_t rx_string,
	output uart_frame_pkg::frame_len_t    rx_length,
	output logic                         rx_busy,
	output logic                         rx_done,
	output logic                         rx_err
);

	import uart_frame_pkg::*;

	localparam int MAX_BYTES = `FRAME_MAX_BYTES;
	localparam int STR_W     = MAX_BYTES * 8;

	typedef enum logic [1:0] {
		R_IDLE,
		R_OPEN,
		R_BODY,
		R_CLOSE
	} parse_state_t;

	parse_state_t  state;
	frame_string_t work_str;
	frame_len_t    work_len;
	logic          is_mark;
	logic          full;
	logic          store;
	logic          finish;

	assign is_mark = (rx_beat.data == `FRAME_MARK);
	assign full    = (work_len == frame_len_t'(MAX_BYTES));
	assign store   = rx_beat.valid && state == R_BODY && !is_mark && !full;
	assign finish  = rx_beat.valid && state == R_CLOSE && is_mark;
	assign rx_busy = (state != R_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= R_IDLE;
			work_len <= '0;
			rx_done  <= 1'b0;
			rx_err   <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			rx_err  <= 1'b0;
			if (rx_beat.valid) begin
				case (state)
					R_IDLE: if (is_mark)
						state <= R_OPEN;
					R_OPEN: begin
						if (is_mark) begin
							state    <= R_BODY;
							work_len <= '0;
						end else begin
							state  <= R_IDLE;
							rx_err <= 1'b1;
						end
					end
					R_BODY: begin
						if (is_mark) begin
							state <= R_CLOSE;
						end else if (full) begin
							// payload overrun
							state  <= R_IDLE;
							rx_err <= 1'b1;
						end else begin
							work_len <= work_len + 1'b1;
						end
					end
					R_CLOSE: begin
						state   <= R_IDLE;
						rx_done <= is_mark;
						rx_err  <= !is_mark;
					end
					default: state <= R_IDLE;
				endcase
			end
		end
	end

	// bytes enter at the top and are right-aligned on completion
	always_ff @(posedge sys_clk) begin
		if (store)
			work_str <= {rx_beat.data, work_str[STR_W-1:8]};
		if (finish) begin
			rx_string <= work_str >> (8 * (MAX_BYTES - int'(work_len)));
			rx_length <= work_len;
		end
	end

	// done and error never pulse together
	a_single_outcome: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_err)
	);

endmodule

// ==== design/frame_tx.sv ====
//********************
// wraps a string as &&payload&& into the serializer
// tx_length must not exceed FRAME_MAX_BYTES
// string and length are captured when tx_req is taken
//********************
`timescale 1ns/100ps
`include "uart_frame_macros.svh"

module frame_tx (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  uart_frame_pkg::frame_string_t tx_string,
	input  uart_frame_pkg::frame_len_t    tx_length,
	input  logic                         tx_req,
	output logic                         tx_busy,
	output logic                         tx_done,
	output logic [7:0]                   byte_data,
	output logic                         byte_req,
	input  logic                         byte_done
);

	import uart_frame_pkg::*;

	// one-hot states
	localparam logic [6:0] ST_IDLE    = 7'b000_0001;
	localparam logic [6:0] ST_MARK1   = 7'b000_0010;
	localparam logic [6:0] ST_MARK2   = 7'b000_0100;
	localparam logic [6:0] ST_CONTENT = 7'b000_1000;
	localparam logic [6:0] ST_MARK3   = 7'b001_0000;
	localparam logic [6:0] ST_MARK4   = 7'b010_0000;
	localparam logic [6:0] ST_FINISH  = 7'b100_0000;

	logic [6:0]    state;
	logic [6:0]    next_state;
	logic          accept;
	logic          issue;
	logic          shift;
	logic [7:0]    next_data;
	frame_string_t str_q;
	frame_len_t    len_q;
	frame_len_t    byte_cnt;
	logic          in_flight;

	// finish counts as idle, so a new request can be taken there
	assign accept  = tx_req && (state == ST_IDLE || state == ST_FINISH);
	assign tx_busy = !(state == ST_IDLE || state == ST_FINISH);
	assign tx_done = (state == ST_FINISH);
	assign shift   = issue && (next_state == ST_CONTENT);

	always_comb begin
		next_state = state;
		issue      = 1'b0;
		next_data  = `FRAME_MARK;
		case (state)
			ST_IDLE, ST_FINISH: begin
				next_state = accept ? ST_MARK1 : ST_IDLE;
				issue      = accept;
			end
			ST_MARK1: if (byte_done) begin
				next_state = ST_MARK2;
				issue      = 1'b1;
			end
			// empty string goes straight to the closing marks
			ST_MARK2, ST_CONTENT: if (byte_done) begin
				issue = 1'b1;
				if (byte_cnt == len_q) begin
					next_state = ST_MARK3;
				end else begin
					next_state = ST_CONTENT;
					next_data  = str_q[7:0];
				end
			end
			ST_MARK3: if (byte_done) begin
				next_state = ST_MARK4;
				issue      = 1'b1;
			end
			ST_MARK4: if (byte_done)
				next_state = ST_FINISH;
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= ST_IDLE;
			byte_req  <= 1'b0;
			byte_cnt  <= '0;
			in_flight <= 1'b0;
		end else begin
			state    <= next_state;
			byte_req <= issue;
			if (accept)
				byte_cnt <= '0;
			else if (shift)
				byte_cnt <= byte_cnt + 1'b1;
			if (byte_req)
				in_flight <= 1'b1;
			else if (byte_done)
				in_flight <= 1'b0;
		end
	end

	// payload bytes leave from the bottom of the latched copy
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			str_q <= tx_string;
			len_q <= tx_length;
		end else if (shift) begin
			str_q <= str_q >> 8;
		end
		if (issue)
			byte_data <= next_data;
	end

	a_no_req_while_sending: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> !in_flight
	);

endmodule

// ==== design/uart_frame_macros.svh ====
//********************
// build-time constants for the framed string link
// FRAME_CLKS_PER_BIT must be even and at least 4
// FRAME_MARK may not appear inside a payload
//********************
`ifndef UART_FRAME_MACROS_SVH
`define UART_FRAME_MACROS_SVH

// payload capacity of one string in bytes
`define FRAME_MAX_BYTES 16

// sys_clk cycles per serial bit
`define FRAME_CLKS_PER_BIT 16

// delimiter byte is ascii '&'
`define FRAME_MARK 8'h26

`endif

// ==== design/uart_frame_pkg.sv ====
//********************
// shared types of the framed string link
// byte 0 of a string sits in bits 7:0 and goes out first
//********************
`include "uart_frame_macros.svh"

package uart_frame_pkg;

	// whole string with byte 0 in the lowest bits
	typedef logic [`FRAME_MAX_BYTES*8-1:0] frame_string_t;

	// byte count from 0 up to FRAME_MAX_BYTES inclusive
	typedef logic [$clog2(`FRAME_MAX_BYTES+1)-1:0] frame_len_t;

	// one received character
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} byte_beat_t;

endpackage

// ==== design/uart_frame_top.sv ====
//********************
// framed string link over one 8N1 uart
// transmit path runs frame_tx into uart_tx
// receive path runs uart_rx into frame_rx
//********************
`timescale 1ns/100ps

module uart_frame_top (
	input  logic                          sys_clk,
	input  logic                          sys_rst_n,
	input  uart_frame_pkg::frame_string_t tx_string,
	input  uart_frame_pkg::frame_len_t    tx_length,
	input  logic                          tx_req,
	output logic                          tx_busy,
	output logic                          tx_done,
	output uart_frame_pkg::frame_string_t rx_string,
	output uart_frame_pkg::frame_len_t    rx_length,
	output logic                          rx_busy,
	output logic                          rx_done,
	output logic                          rx_err,
	input  logic                          uart_rx_port,
	output logic                          uart_tx_port
);

	import uart_frame_pkg::*;

	logic [7:0] byte_data;
	logic       byte_req;
	logic       byte_done;
	byte_beat_t rx_beat;

	// transmit pipeline
	frame_tx u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.tx_line   (uart_tx_port),
		.byte_done (byte_done)
	);

	// receive pipeline
	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_line   (uart_rx_port),
		.rx_beat   (rx_beat)
	);

	frame_rx u_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_beat   (rx_beat),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_err    (rx_err)
	);

endmodule

// ==== design/uart_rx.sv ====
//********************
// 8N1 receiver, samples at mid-bit
// a start bit gone high at mid-bit counts as a glitch
// a byte with a low stop bit gives no beat
//********************
`timescale 1ns/100ps
`include "uart_frame_macros.svh"

module uart_rx (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  logic                      rx_line,
	output uart_frame_pkg::byte_beat_t rx_beat
);

	localparam int CPB    = `FRAME_CLKS_PER_BIT;
	localparam int HALF   = CPB / 2;
	localparam int BAUD_W = $clog2(CPB);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t         state;
	logic              rx_meta;
	logic              rx_sync;
	logic              rx_prev;
	logic              fall;
	logic [2:0]        bit_cnt;
	logic [BAUD_W-1:0] baud_cnt;
	logic [7:0]        data_sr;
	logic              beat_valid;

	assign fall    = rx_prev && !rx_sync;
	assign rx_beat = '{valid: beat_valid, data: data_sr};

	// two-flop synchronizer plus edge history that idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= RX_IDLE;
			bit_cnt    <= 3'd0;
			baud_cnt   <= '0;
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= 1'b0;
			baud_cnt   <= baud_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (fall)
						state <= RX_START;
				end
				// recheck the start bit at its middle
				RX_START: if (baud_cnt == BAUD_W'(HALF - 1)) begin
					baud_cnt <= '0;
					bit_cnt  <= 3'd0;
					state    <= rx_sync ? RX_IDLE : RX_DATA;
				end
				RX_DATA: if (baud_cnt == BAUD_W'(CPB - 1)) begin
					baud_cnt <= '0;
					bit_cnt  <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= RX_STOP;
				end
				// back to idle at mid stop bit where the line is high
				RX_STOP: if (baud_cnt == BAUD_W'(CPB - 1)) begin
					beat_valid <= rx_sync;
					state      <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && baud_cnt == BAUD_W'(CPB - 1))
			data_sr <= {rx_sync, data_sr[7:1]};
	end

endmodule

// ==== design/uart_tx.sv ====
//********************
// 8N1 serializer, one byte per byte_req pulse
// byte_req while a byte is on the line is ignored
// byte_done is high in the last cycle of the stop bit
//********************
`timescale 1ns/100ps
`include "uart_frame_macros.svh"

module uart_tx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_req,
	output logic       tx_line,
	output logic       byte_done
);

	localparam int CPB    = `FRAME_CLKS_PER_BIT;
	localparam int BAUD_W = $clog2(CPB);

	logic              busy;
	logic [3:0]        bit_cnt;
	logic [BAUD_W-1:0] baud_cnt;
	logic [7:0]        data_sr;
	logic              bit_end;

	// bit_cnt 0 is the start bit, 1..8 data, 9 stop
	assign bit_end   = busy && (baud_cnt == BAUD_W'(CPB - 1));
	assign byte_done = bit_end && (bit_cnt == 4'd9);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			bit_cnt  <= 4'd0;
			baud_cnt <= '0;
			tx_line  <= 1'b1;
		end else if (!busy) begin
			bit_cnt  <= 4'd0;
			baud_cnt <= '0;
			if (byte_req) begin
				busy    <= 1'b1;
				tx_line <= 1'b0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			bit_cnt  <= bit_cnt + 4'd1;
			if (bit_cnt == 4'd9) begin
				busy    <= 1'b0;
				tx_line <= 1'b1;
			end else if (bit_cnt == 4'd8) begin
				tx_line <= 1'b1;
			end else begin
				// lsb first
				tx_line <= data_sr[bit_cnt[2:0]];
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!busy && byte_req)
			data_sr <= byte_data;
	end

	a_idle_line_high: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		!busy |-> tx_line
	);

endmodule

// ==== filelist.f ====
+incdir+design
design/uart_frame_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/frame_tx.sv
design/frame_rx.sv
design/uart_frame_top.sv
testbench/tb_uart_frame.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the framed uart testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_uart_frame -o tb_uart_frame
./obj_dir/tb_uart_frame > sim.log 2>&1 || true
cat sim.log
if grep -qx "NO ERRORS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// ==== testbench/tb_uart_frame.sv ====
//********************
// testbench for uart_frame_top with vectors from uart_frame_testdata.txt
// run from the project root so the data path resolves
// mode 0 loops uart_tx_port back and mode 1 injects raw bytes
//********************
`timescale 1ns/100ps
`include "uart_frame_macros.svh"

module tb_uart_frame;

	import uart_frame_pkg::*;

	localparam time CLK_PERIOD   = 100;
	localparam time CLK_HALF     = 50;
	localparam int  CPB          = `FRAME_CLKS_PER_BIT;
	localparam int  N_TESTS      = 10;
	localparam int  SLOTS        = `FRAME_MAX_BYTES + 8;
	// record fields are mode, length, outcome, expected length, expected offset, bytes
	localparam int  F_MODE       = 0;
	localparam int  F_LEN        = 1;
	localparam int  F_OUTCOME    = 2;
	localparam int  F_EXP_LEN    = 3;
	localparam int  F_EXP_OFF    = 4;
	localparam int  F_DATA       = 5;
	localparam int  REC_W        = F_DATA + SLOTS;
	localparam int  WORST_FRAME  = (`FRAME_MAX_BYTES + 4) * 11 * CPB;
	localparam int  LIMIT        = N_TESTS * 2 * WORST_FRAME + 1000;
	localparam int  QUIET        = 3 * 10 * CPB;
	localparam int  OUTCOME_WAIT = 4 * 10 * CPB;

	logic          sys_clk;
	logic          sys_rst_n;
	frame_string_t tx_string;
	frame_len_t    tx_length;
	logic          tx_req;
	logic          tx_busy;
	logic          tx_done;
	frame_string_t rx_string;
	frame_len_t    rx_length;
	logic          rx_busy;
	logic          rx_done;
	logic          rx_err;
	logic          uart_rx_port;
	logic          uart_tx_port;
	logic          loop_mode;
	logic          raw_line;

	logic [7:0] tdata [0:N_TESTS*REC_W-1];
	logic [7:0] last_bytes [0:`FRAME_MAX_BYTES-1];
	int         last_len;
	bit         have_last;
	int         done_pulses;
	int         err_pulses;
	int         busy_faults;
	bit         busy_prev;
	int         error_count;
	int         failed_tests;
	int         cycle_cnt;
	int         t;
	integer     seed = 32'h7500;

	uart_frame_top u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_err       (rx_err),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	// loopback or injected line into the receiver
	assign uart_rx_port = loop_mode ? uart_tx_port : raw_line;

	always #CLK_HALF sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= LIMIT) begin
			$display("timeout: run still busy after %0d cycles", LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// outcome pulses counted at the falling edge
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if (rx_done)
				done_pulses <= done_pulses + 1;
			if (rx_err)
				err_pulses <= err_pulses + 1;
			// rx_busy has to cover the cycle before each outcome pulse
			if ((rx_done || rx_err) && !busy_prev)
				busy_faults <= busy_faults + 1;
			busy_prev <= rx_busy;
		end
	end

	function automatic logic [7:0] rec_byte(input int rec, input int idx);
		return tdata[rec*REC_W + idx];
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("ERR @%0t: %s is %0h, expected %0h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	// one 8N1 character on the raw line followed by a short random idle gap
	task automatic send_serial(input logic [7:0] b);
		logic [9:0] bits;
		int         gap;
		int         i;
		bits = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			raw_line <= bits[i];
			repeat (CPB - 1) @(posedge sys_clk);
		end
		gap = $random(seed) & 32'h0000_000f;
		repeat (gap) @(posedge sys_clk);
	endtask

	task automatic run_loopback(input int rec);
		frame_string_t str;
		frame_len_t    len;
		time           t0;
		int            chars;
		int            wait_cnt;
		int            i;
		bit            busy_gap;
		str = '0;
		len = frame_len_t'(rec_byte(rec, F_LEN));
		for (i = 0; i < int'(len); i++)
			str[i*8 +: 8] = rec_byte(rec, F_DATA + i);
		chars = int'(len) + 4;
		@(posedge sys_clk);
		tx_string <= str;
		tx_length <= len;
		tx_req    <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		t0 = $time;
		@(negedge sys_clk);
		check_value(32'(tx_busy), 32'd1, "tx_busy after tx_req");
		// a request while busy must be dropped
		repeat (3) @(posedge sys_clk);
		tx_string <= ~str;
		tx_req    <= 1'b1;
		@(posedge sys_clk);
		tx_req   <= 1'b0;
		busy_gap = 1'b0;
		wait_cnt = 0;
		do begin
			@(negedge sys_clk);
			wait_cnt++;
			if (!tx_done && !tx_busy)
				busy_gap = 1'b1;
		end while (!tx_done && wait_cnt < chars * 11 * CPB);
		if (!tx_done) begin
			$display("test %0d: tx_done never came after tx_req", rec);
			error_count++;
		end else begin
			// each character is ten bit times plus one cycle to re-issue
			check_value(32'((($time - t0) - CLK_HALF) / CLK_PERIOD),
				32'(chars * (10 * CPB + 1)), "cycles from tx_req to tx_done");
			check_value(32'(tx_busy), 32'd0, "tx_busy during tx_done");
			check_value(32'(busy_gap), 32'd0, "tx_busy low before tx_done");
		end
	endtask

	task automatic run_test(input int rec);
		int mode;
		int outcome;
		int exp_len;
		int exp_off;
		int errs_before;
		int snap_done;
		int snap_err;
		int snap_busy;
		int n;
		int i;
		mode        = int'(rec_byte(rec, F_MODE));
		outcome     = int'(rec_byte(rec, F_OUTCOME));
		exp_len     = int'(rec_byte(rec, F_EXP_LEN));
		exp_off     = int'(rec_byte(rec, F_EXP_OFF));
		errs_before = error_count;
		snap_done   = done_pulses;
		snap_err    = err_pulses;
		snap_busy   = busy_faults;
		@(posedge sys_clk);
		loop_mode <= (mode == 0);
		if (mode == 0) begin
			run_loopback(rec);
		end else begin
			for (i = 0; i < int'(rec_byte(rec, F_LEN)); i++)
				send_serial(rec_byte(rec, F_DATA + i));
		end
		n = 0;
		while (done_pulses + err_pulses == snap_done + snap_err && n < OUTCOME_WAIT) begin
			@(negedge sys_clk);
			n++;
		end
		if (done_pulses + err_pulses == snap_done + snap_err) begin
			$display("test %0d: receiver gave neither rx_done nor rx_err", rec);
			error_count++;
		end
		// idle window that catches a second frame or a late pulse
		repeat (QUIET) @(negedge sys_clk);
		check_value(32'(done_pulses - snap_done), (outcome == 1) ? 32'd1 : 32'd0, "rx_done count");
		check_value(32'(err_pulses - snap_err), (outcome == 2) ? 32'd1 : 32'd0, "rx_err count");
		check_value(32'(busy_faults - snap_busy), 32'd0, "rx_busy low before outcome");
		check_value(32'({tx_busy, rx_busy}), 32'd0, "busy levels after frame");
		if (outcome == 1) begin
			check_value(32'(rx_length), 32'(exp_len), "rx_length");
			for (i = 0; i < exp_len; i++) begin
				check_value(32'(rx_string[i*8 +: 8]),
					32'(rec_byte(rec, F_DATA + exp_off + i)), "rx_string byte");
				last_bytes[i] = rec_byte(rec, F_DATA + exp_off + i);
			end
			last_len  = exp_len;
			have_last = 1'b1;
		end else if (have_last) begin
			// an error leaves the last good string in place
			check_value(32'(rx_length), 32'(last_len), "rx_length kept after rx_err");
			for (i = 0; i < last_len; i++)
				check_value(32'(rx_string[i*8 +: 8]), 32'(last_bytes[i]), "rx_string kept");
		end
		if (error_count == errs_before) begin
			$display("test %0d %s: pass", rec, (mode == 0) ? "loopback" : "raw");
		end else begin
			$display("test %0d %s: fail", rec, (mode == 0) ? "loopback" : "raw");
			failed_tests++;
		end
	endtask

	initial begin
		sys_clk = 1'b0;
		sys_rst_n <= 1'b0;
		tx_string <= '0;
		tx_length <= '0;
		tx_req    <= 1'b0;
		loop_mode <= 1'b0;
		raw_line  <= 1'b1;
		$readmemh("testbench/uart_frame_testdata.txt", tdata);
		repeat (5) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		check_value(32'({tx_busy, tx_done, rx_busy, rx_done, rx_err, uart_tx_port}),
			32'b000001, "outputs after reset");
		for (t = 0; t < N_TESTS; t++)
			run_test(t);
		$display("tests %0d, failed %0d, errors %0d", N_TESTS, failed_tests, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== testbench/uart_frame_testdata.txt ====
// columns: mode (0 loopback, 1 raw), length, outcome (1 done, 2 error),
// expected length, offset of expected bytes, then 24 byte slots
// loopback "A"
00 01 01 01 00 41 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// loopback "hello"
00 05 01 05 00 68 65 6c 6c 6f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// loopback full string
00 10 01 10 00 30 31 32 33 34 35 36 37 38 39 61 62 63 64 65 66 00 00 00 00 00 00 00 00
// loopback empty string
00 00 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// raw, second opening mark missing
01 02 02 00 00 26 78 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// raw, idle garbage then "abc"
01 0a 01 03 05 67 71 7a 26 26 61 62 63 26 26 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// raw, content mark followed by a payload byte
01 05 02 00 00 26 26 61 26 62 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// raw, 17 payload bytes
01 13 02 00 00 26 26 61 61 61 61 61 61 61 61 61 61 61 61 61 61 61 61 61 00 00 00 00 00
// raw, empty payload with a bad closing byte
01 04 02 00 00 26 26 26 7a 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// loopback "uart ok"
00 07 01 07 00 75 61 72 74 20 6f 6b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
